// ==== Makefile ====
# Verilator build and run for the packet performance monitor testbench

TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_pkt_perf
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the log decides the verdict, the simulator exit code is not used
sim: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "no verdict found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hw/perf_defs_pkg.sv ====
// performance monitor definitions
// counter, timestamp and stream field widths
package perf_defs_pkg;

   ///////////////////////////////////////////////////////////////////////
   // widths
   ///////////////////////////////////////////////////////////////////////

   // packet counters
   localparam int CNT_W = 64;

   // free-running timebase and logged timestamps
   localparam int TS_W = 64;

   // rx error field, one bit per error class
   localparam int ERR_W = 6;

   ///////////////////////////////////////////////////////////////////////
   // types
   ///////////////////////////////////////////////////////////////////////

   typedef logic [CNT_W-1:0] cnt_t;

   typedef logic [TS_W-1:0] ts_t;

endpackage

// ==== hw/perf_snapshot.sv ====
// performance timebase and snapshot
// free-running cycle counter, live values frozen while stalled
`timescale 1ns/100ps

module perf_snapshot (
   input  logic                i_clk_status,
   input  logic                i_clear,
   input  logic                i_stall,
   output perf_defs_pkg::ts_t  o_timebase,
   input  perf_defs_pkg::cnt_t i_tx_pkt_cnt,
   input  perf_defs_pkg::cnt_t i_rx_pkt_cnt,
   input  perf_defs_pkg::cnt_t i_rx_good_cnt,
   input  perf_defs_pkg::ts_t  i_tx_start_ts,
   input  perf_defs_pkg::ts_t  i_tx_end_ts,
   input  perf_defs_pkg::ts_t  i_rx_start_ts,
   input  perf_defs_pkg::ts_t  i_rx_end_ts,
   perf_snapshot_if.source     snap
);

   // timebase, one tick per status clock
   always_ff @(posedge i_clk_status) begin
      if (i_clear) begin
         o_timebase <= '0;
      end else begin
         o_timebase <= o_timebase + 1'b1;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // readable copy
   ///////////////////////////////////////////////////////////////////////

   // live values keep running underneath a stall
   always_ff @(posedge i_clk_status) begin
      if (!i_stall) begin
         snap.tx_pkt_cnt  <= i_tx_pkt_cnt;
         snap.rx_pkt_cnt  <= i_rx_pkt_cnt;
         snap.rx_good_cnt <= i_rx_good_cnt;
         snap.tx_start_ts <= i_tx_start_ts;
         snap.tx_end_ts   <= i_tx_end_ts;
         snap.rx_start_ts <= i_rx_start_ts;
         snap.rx_end_ts   <= i_rx_end_ts;
      end
   end

endmodule

// ==== hw/perf_snapshot_if.sv ====
// frozen performance values
// snapshot registers towards the register block
`timescale 1ns/100ps

interface perf_snapshot_if;
   import perf_defs_pkg::*;

   cnt_t tx_pkt_cnt;
   cnt_t rx_pkt_cnt;
   cnt_t rx_good_cnt;

   ts_t  tx_start_ts;
   ts_t  tx_end_ts;
   ts_t  rx_start_ts;
   ts_t  rx_end_ts;

   modport source (output tx_pkt_cnt, rx_pkt_cnt, rx_good_cnt,
                   tx_start_ts, tx_end_ts, rx_start_ts, rx_end_ts);

   modport sink (input tx_pkt_cnt, rx_pkt_cnt, rx_good_cnt,
                 tx_start_ts, tx_end_ts, rx_start_ts, rx_end_ts);

endinterface

// ==== hw/pkt_perf_top.sv ====
// packet client performance monitor
// tx and rx monitors, snapshot and status registers on the status clock
`timescale 1ns/100ps

module pkt_perf_top #(
   parameter logic [5:0]                   STATUS_ADDR_PREFIX = 6'b000100,
   parameter status_map_pkg::status_word_t FEATURES           = '0
) (
   input  logic                                  i_clk_status,
   input  logic                                  perf_count_rst,
   input  logic                                  i_tx_valid,
   input  logic                                  i_tx_ready,
   input  logic                                  i_tx_sop,
   input  logic                                  i_tx_eop,
   input  logic                                  i_rx_valid,
   input  logic                                  i_rx_sop,
   input  logic                                  i_rx_eop,
   input  logic [perf_defs_pkg::ERR_W-1:0]       i_rx_error,
   input  logic [status_map_pkg::BUS_ADDR_W-1:0] i_status_addr,
   input  logic                                  i_status_read,
   input  logic                                  i_status_write,
   input  status_map_pkg::status_word_t          i_status_writedata,
   output status_map_pkg::status_word_t          o_status_readdata,
   output logic                                  o_status_readdata_valid
);
   import perf_defs_pkg::*;

   ts_t  timebase;
   cnt_t tx_pkt_cnt;
   cnt_t rx_pkt_cnt;
   cnt_t rx_good_cnt;
   ts_t  tx_start_ts;
   ts_t  tx_end_ts;
   ts_t  rx_start_ts;
   ts_t  rx_end_ts;
   logic perf_clear;
   logic snap_stall;

   perf_snapshot_if snap_if ();

   tx_perf_monitor u_tx_mon (
      .i_clk_status (i_clk_status),
      .i_clear      (perf_clear),
      .i_valid      (i_tx_valid),
      .i_ready      (i_tx_ready),
      .i_sop        (i_tx_sop),
      .i_eop        (i_tx_eop),
      .i_timebase   (timebase),
      .o_pkt_cnt    (tx_pkt_cnt),
      .o_start_ts   (tx_start_ts),
      .o_end_ts     (tx_end_ts)
   );

   rx_perf_monitor u_rx_mon (
      .i_clk_status (i_clk_status),
      .i_clear      (perf_clear),
      .i_valid      (i_rx_valid),
      .i_sop        (i_rx_sop),
      .i_eop        (i_rx_eop),
      .i_error      (i_rx_error),
      .i_timebase   (timebase),
      .o_pkt_cnt    (rx_pkt_cnt),
      .o_good_cnt   (rx_good_cnt),
      .o_start_ts   (rx_start_ts),
      .o_end_ts     (rx_end_ts)
   );

   perf_snapshot u_snapshot (
      .i_clk_status  (i_clk_status),
      .i_clear       (perf_clear),
      .i_stall       (snap_stall),
      .o_timebase    (timebase),
      .i_tx_pkt_cnt  (tx_pkt_cnt),
      .i_rx_pkt_cnt  (rx_pkt_cnt),
      .i_rx_good_cnt (rx_good_cnt),
      .i_tx_start_ts (tx_start_ts),
      .i_tx_end_ts   (tx_end_ts),
      .i_rx_start_ts (rx_start_ts),
      .i_rx_end_ts   (rx_end_ts),
      .snap          (snap_if.source)
   );

   status_regs #(
      .STATUS_ADDR_PREFIX (STATUS_ADDR_PREFIX),
      .FEATURES           (FEATURES)
   ) u_status_regs (
      .i_clk_status            (i_clk_status),
      .perf_count_rst          (perf_count_rst),
      .i_status_addr           (i_status_addr),
      .i_status_read           (i_status_read),
      .i_status_write          (i_status_write),
      .i_status_writedata      (i_status_writedata),
      .o_status_readdata       (o_status_readdata),
      .o_status_readdata_valid (o_status_readdata_valid),
      .o_perf_clear            (perf_clear),
      .o_snap_stall            (snap_stall),
      .snap                    (snap_if.sink)
   );

endmodule

// ==== hw/rx_perf_monitor.sv ====
// receive performance monitor
// counts all and error-free packets, logs first sop and last eop times
`timescale 1ns/100ps

module rx_perf_monitor (
   input  logic                             i_clk_status,
   input  logic                             i_clear,
   input  logic                             i_valid,
   input  logic                             i_sop,
   input  logic                             i_eop,
   input  logic [perf_defs_pkg::ERR_W-1:0]  i_error,
   input  perf_defs_pkg::ts_t               i_timebase,
   output perf_defs_pkg::cnt_t              o_pkt_cnt,
   output perf_defs_pkg::cnt_t              o_good_cnt,
   output perf_defs_pkg::ts_t               o_start_ts,
   output perf_defs_pkg::ts_t               o_end_ts
);
   import perf_defs_pkg::*;

   logic             valid_q1, sop_q1, eop_q1;
   logic             valid_q2, sop_q2, eop_q2;
   logic [ERR_W-1:0] error_q1;
   logic [ERR_W-1:0] error_q2;
   logic             got_sop;
   logic             got_eop;
   logic             start_logged;

   always_ff @(posedge i_clk_status) begin
      valid_q1 <= i_valid;
      sop_q1   <= i_sop;
      eop_q1   <= i_eop;
      error_q1 <= i_error;
      valid_q2 <= valid_q1;
      sop_q2   <= sop_q1;
      eop_q2   <= eop_q1;
      error_q2 <= error_q1;
   end

   // no back-pressure on rx, valid alone qualifies a beat
   assign got_sop = valid_q2 & sop_q2;
   assign got_eop = valid_q2 & eop_q2;

   always_ff @(posedge i_clk_status) begin
      if (i_clear) begin
         o_pkt_cnt    <= '0;
         o_good_cnt   <= '0;
         start_logged <= 1'b0;
         o_start_ts   <= '0;
         o_end_ts     <= '0;
      end else begin
         if (got_eop) begin
            o_pkt_cnt <= o_pkt_cnt + 1'b1;
            o_end_ts  <= i_timebase;
            if (error_q2 == '0) begin
               o_good_cnt <= o_good_cnt + 1'b1;
            end
         end
         if (got_sop) begin
            start_logged <= 1'b1;
         end
         if (!start_logged) begin
            o_start_ts <= i_timebase;
         end
      end
   end

endmodule

// ==== hw/status_map_pkg.sv ====
// status register map
// bus widths, register offsets and fixed read words
package status_map_pkg;

   // full bus address and the offset inside this block
   localparam int BUS_ADDR_W = 16;
   localparam int REG_ADDR_W = 6;
   localparam int BUS_DATA_W = 32;

   typedef logic [BUS_DATA_W-1:0] status_word_t;

   ///////////////////////////////////////////////////////////////////////
   // register offsets
   ///////////////////////////////////////////////////////////////////////

   typedef enum logic [REG_ADDR_W-1:0] {
      REG_SCRATCH     = 6'h00,
      REG_ID          = 6'h01,
      REG_FEATURES    = 6'h02,
      REG_CTRL        = 6'h18,
      REG_TX_CNT_LO   = 6'h19,
      REG_TX_CNT_HI   = 6'h1A,
      REG_RX_CNT_LO   = 6'h1B,
      REG_RX_CNT_HI   = 6'h1C,
      REG_RX_GOOD_LO  = 6'h1D,
      REG_RX_GOOD_HI  = 6'h1E,
      REG_TX_START_LO = 6'h1F,
      REG_TX_START_HI = 6'h20,
      REG_TX_END_LO   = 6'h21,
      REG_TX_END_HI   = 6'h22,
      REG_RX_START_LO = 6'h23,
      REG_RX_START_HI = 6'h24,
      REG_RX_END_LO   = 6'h25,
      REG_RX_END_HI   = 6'h26
   } reg_addr_e;

   // ascii CLNT
   localparam status_word_t ID_WORD = "CLNT";

   localparam status_word_t UNMAPPED_WORD = 32'h0000_0123;

endpackage

// ==== hw/status_regs.sv ====
// status register block
// bus decode, scratch and control registers, snapshot read-back
`timescale 1ns/100ps

module status_regs #(
   parameter logic [5:0]                   STATUS_ADDR_PREFIX = 6'b000100,
   parameter status_map_pkg::status_word_t FEATURES           = '0
) (
   input  logic                                  i_clk_status,
   input  logic                                  perf_count_rst,
   input  logic [status_map_pkg::BUS_ADDR_W-1:0] i_status_addr,
   input  logic                                  i_status_read,
   input  logic                                  i_status_write,
   input  status_map_pkg::status_word_t          i_status_writedata,
   output status_map_pkg::status_word_t          o_status_readdata,
   output logic                                  o_status_readdata_valid,
   output logic                                  o_perf_clear,
   output logic                                  o_snap_stall,
   perf_snapshot_if.sink                         snap
);
   import status_map_pkg::*;

   logic         read_r;
   logic         write_r;
   logic         sel_r;
   reg_addr_e    offset_r;
   status_word_t writedata_r;

   status_word_t scratch;
   logic         ctrl_stall;
   logic         ctrl_log_reset;

   ///////////////////////////////////////////////////////////////////////
   // bus capture
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst) begin
         read_r  <= 1'b0;
         write_r <= 1'b0;
         sel_r   <= 1'b0;
      end else begin
         read_r  <= i_status_read;
         write_r <= i_status_write;
         sel_r   <= (i_status_addr[BUS_ADDR_W-1:REG_ADDR_W] == {STATUS_ADDR_PREFIX, 4'b0000});
      end
   end

   always_ff @(posedge i_clk_status) begin
      offset_r    <= reg_addr_e'(i_status_addr[REG_ADDR_W-1:0]);
      writedata_r <= i_status_writedata;
   end

   // writable registers, everything else read-only
   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst) begin
         scratch        <= '0;
         ctrl_stall     <= 1'b0;
         ctrl_log_reset <= 1'b0;
      end else if (write_r && sel_r) begin
         case (offset_r)
            REG_SCRATCH: scratch <= writedata_r;
            REG_CTRL: begin
               ctrl_stall     <= writedata_r[1];
               ctrl_log_reset <= writedata_r[0];
            end
            default: ;
         endcase
      end
   end

   // counters and timebase held in clear while this is high
   always_ff @(posedge i_clk_status) begin
      o_perf_clear <= perf_count_rst | ctrl_log_reset;
   end

   assign o_snap_stall = ctrl_stall;

   ///////////////////////////////////////////////////////////////////////
   // read-back
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst) begin
         o_status_readdata_valid <= 1'b0;
      end else begin
         o_status_readdata_valid <= read_r & sel_r;
      end
   end

   always_ff @(posedge i_clk_status) begin
      if (read_r && sel_r) begin
         case (offset_r)
            REG_SCRATCH:     o_status_readdata <= scratch;
            REG_ID:          o_status_readdata <= ID_WORD;
            REG_FEATURES:    o_status_readdata <= FEATURES;
            REG_CTRL:        o_status_readdata <= {{(BUS_DATA_W-2){1'b0}},
                                                   ctrl_stall, ctrl_log_reset};
            REG_TX_CNT_LO:   o_status_readdata <= snap.tx_pkt_cnt[BUS_DATA_W-1:0];
            REG_TX_CNT_HI:   o_status_readdata <= snap.tx_pkt_cnt[2*BUS_DATA_W-1:BUS_DATA_W];
            REG_RX_CNT_LO:   o_status_readdata <= snap.rx_pkt_cnt[BUS_DATA_W-1:0];
            REG_RX_CNT_HI:   o_status_readdata <= snap.rx_pkt_cnt[2*BUS_DATA_W-1:BUS_DATA_W];
            REG_RX_GOOD_LO:  o_status_readdata <= snap.rx_good_cnt[BUS_DATA_W-1:0];
            REG_RX_GOOD_HI:  o_status_readdata <= snap.rx_good_cnt[2*BUS_DATA_W-1:BUS_DATA_W];
            REG_TX_START_LO: o_status_readdata <= snap.tx_start_ts[BUS_DATA_W-1:0];
            REG_TX_START_HI: o_status_readdata <= snap.tx_start_ts[2*BUS_DATA_W-1:BUS_DATA_W];
            REG_TX_END_LO:   o_status_readdata <= snap.tx_end_ts[BUS_DATA_W-1:0];
            REG_TX_END_HI:   o_status_readdata <= snap.tx_end_ts[2*BUS_DATA_W-1:BUS_DATA_W];
            REG_RX_START_LO: o_status_readdata <= snap.rx_start_ts[BUS_DATA_W-1:0];
            REG_RX_START_HI: o_status_readdata <= snap.rx_start_ts[2*BUS_DATA_W-1:BUS_DATA_W];
            REG_RX_END_LO:   o_status_readdata <= snap.rx_end_ts[BUS_DATA_W-1:0];
            REG_RX_END_HI:   o_status_readdata <= snap.rx_end_ts[2*BUS_DATA_W-1:BUS_DATA_W];
            default:         o_status_readdata <= UNMAPPED_WORD;
         endcase
      end
   end

endmodule

// ==== hw/tx_perf_monitor.sv ====
// transmit performance monitor
// counts accepted packets and logs first sop and last eop times
`timescale 1ns/100ps

module tx_perf_monitor (
   input  logic                i_clk_status,
   input  logic                i_clear,
   input  logic                i_valid,
   input  logic                i_ready,
   input  logic                i_sop,
   input  logic                i_eop,
   input  perf_defs_pkg::ts_t  i_timebase,
   output perf_defs_pkg::cnt_t o_pkt_cnt,
   output perf_defs_pkg::ts_t  o_start_ts,
   output perf_defs_pkg::ts_t  o_end_ts
);

   logic valid_q1, ready_q1, sop_q1, eop_q1;
   logic valid_q2, ready_q2, sop_q2, eop_q2;
   logic acc_sop;
   logic acc_eop;
   logic start_logged;

   // two sampling stages on the handshake
   always_ff @(posedge i_clk_status) begin
      valid_q1 <= i_valid;
      ready_q1 <= i_ready;
      sop_q1   <= i_sop;
      eop_q1   <= i_eop;
      valid_q2 <= valid_q1;
      ready_q2 <= ready_q1;
      sop_q2   <= sop_q1;
      eop_q2   <= eop_q1;
   end

   assign acc_sop = valid_q2 & ready_q2 & sop_q2;
   assign acc_eop = valid_q2 & ready_q2 & eop_q2;

   always_ff @(posedge i_clk_status) begin
      if (i_clear) begin
         o_pkt_cnt    <= '0;
         start_logged <= 1'b0;
         o_start_ts   <= '0;
         o_end_ts     <= '0;
      end else begin
         if (acc_eop) begin
            o_pkt_cnt <= o_pkt_cnt + 1'b1;
            o_end_ts  <= i_timebase;
         end
         if (acc_sop) begin
            start_logged <= 1'b1;
         end
         // tracks the timebase until the first accepted sop
         if (!start_logged) begin
            o_start_ts <= i_timebase;
         end
      end
   end

endmodule

// ==== tb.f ====
hw/perf_defs_pkg.sv
hw/status_map_pkg.sv
hw/perf_snapshot_if.sv
hw/tx_perf_monitor.sv
hw/rx_perf_monitor.sv
hw/perf_snapshot.sv
hw/status_regs.sv
hw/pkt_perf_top.sv
verification/tb_pkt_perf.sv

// ==== verification/perf_stimulus.txt ====
# one command per line, all operands hex
# WR addr data | RD addr expected | RDX addr | TX count gap | RXG n | RXE n | IDLE n | TSPAN
WR 1000 a5c30f1e
RD 1000 a5c30f1e
RD 1001 434c4e54
RD 1002 00000000
RD 1017 00000123
RDX 2000
TX 5 0
IDLE 4
RD 1019 00000005
RD 101a 00000000
TSPAN
RXG 3
RXE 2
IDLE 4
RD 101b 00000005
RD 101d 00000003
WR 1018 00000002
RD 1018 00000002
TX 3 2
RXG 2
IDLE 4
RD 1019 00000005
RD 101b 00000005
RD 101d 00000003
WR 1018 00000000
IDLE 4
RD 1019 00000008
RD 101b 00000007
RD 101d 00000005
TSPAN
WR 1018 00000001
IDLE 4
RD 1019 00000000
RD 101b 00000000
RD 101d 00000000
RD 101f 00000000
RD 1021 00000000
RD 1023 00000000
RD 1025 00000000
WR 1018 00000000
IDLE 4
RD 1019 00000000
RD 101b 00000000
RD 101d 00000000

// ==== verification/tb_pkt_perf.sv ====
// packet performance monitor testbench
// file-driven bus and stream stimulus with read-back checks
`timescale 1ns/100ps

module tb_pkt_perf;
   import perf_defs_pkg::*;
   import status_map_pkg::*;

   localparam int        CLK_PERIOD = 20;
   localparam int        MARGIN     = 200;
   localparam int        MAX_GAP    = 7;
   localparam logic [9:0] BLOCK_BASE = 10'h040;

   logic                  i_clk_status;
   logic                  perf_count_rst;
   logic                  i_tx_valid;
   logic                  i_tx_ready;
   logic                  i_tx_sop;
   logic                  i_tx_eop;
   logic                  i_rx_valid;
   logic                  i_rx_sop;
   logic                  i_rx_eop;
   logic [ERR_W-1:0]      i_rx_error;
   logic [BUS_ADDR_W-1:0] i_status_addr;
   logic                  i_status_read;
   logic                  i_status_write;
   status_word_t          i_status_writedata;
   status_word_t          o_status_readdata;
   logic                  o_status_readdata_valid;

   // parsed stimulus file
   string       cmd_q[$];
   logic [31:0] arg_a_q[$];
   logic [31:0] arg_b_q[$];

   logic [31:0] lcg_state;
   int          cycle_cnt = 0;
   int          cycle_limit;
   int          error_cnt;

   // tx beats since the last clear
   logic        tx_seen;
   int          tx_first_cycle;
   int          tx_last_cycle;

   pkt_perf_top uut (
      .i_clk_status            (i_clk_status),
      .perf_count_rst          (perf_count_rst),
      .i_tx_valid              (i_tx_valid),
      .i_tx_ready              (i_tx_ready),
      .i_tx_sop                (i_tx_sop),
      .i_tx_eop                (i_tx_eop),
      .i_rx_valid              (i_rx_valid),
      .i_rx_sop                (i_rx_sop),
      .i_rx_eop                (i_rx_eop),
      .i_rx_error              (i_rx_error),
      .i_status_addr           (i_status_addr),
      .i_status_read           (i_status_read),
      .i_status_write          (i_status_write),
      .i_status_writedata      (i_status_writedata),
      .o_status_readdata       (o_status_readdata),
      .o_status_readdata_valid (o_status_readdata_valid)
   );

   initial begin
      i_clk_status = 1'b0;
      forever begin
         #(CLK_PERIOD/2) i_clk_status = ~i_clk_status;
      end
   end

   always @(posedge i_clk_status) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("timeout, the run went past %0d cycles", cycle_limit);
         stop_on_failure();
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // helpers
   ///////////////////////////////////////////////////////////////////////

   task automatic stop_on_failure();
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
         error_cnt++;
         stop_on_failure();
      end
   endtask

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [BUS_ADDR_W-1:0] block_addr(input logic [REG_ADDR_W-1:0] off);
      return {BLOCK_BASE, off};
   endfunction

   // all stream and bus tasks start and end just after a falling edge
   task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr, input status_word_t data);
      i_status_addr      = addr;
      i_status_writedata = data;
      i_status_write     = 1'b1;
      @(negedge i_clk_status);
      i_status_write = 1'b0;
      // log reset restarts the timestamps
      if (addr == block_addr(REG_CTRL) && data[0]) begin
         tx_seen = 1'b0;
      end
   endtask

   task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr, output status_word_t data,
                           output logic got_valid);
      int wait_cnt;
      i_status_addr = addr;
      i_status_read = 1'b1;
      @(negedge i_clk_status);
      i_status_read = 1'b0;
      got_valid     = 1'b0;
      data          = '0;
      wait_cnt      = 0;
      while (!got_valid && wait_cnt < 2) begin
         got_valid = o_status_readdata_valid;
         data      = o_status_readdata;
         wait_cnt++;
         if (!got_valid && wait_cnt < 2) begin
            @(negedge i_clk_status);
         end
      end
   endtask

   task automatic read_word(input logic [BUS_ADDR_W-1:0] addr, output status_word_t data);
      logic got_valid;
      bus_read(addr, data, got_valid);
      if (!got_valid) begin
         $display("no read data valid within 2 cycles of the read at 0x%04h", addr);
         stop_on_failure();
      end
   endtask

   task automatic send_tx(input int count, input int gap_arg);
      int pkt;
      int gap;
      pkt = 0;
      while (pkt < count) begin
         i_tx_valid = 1'b1;
         i_tx_ready = 1'b1;
         i_tx_sop   = 1'b1;
         i_tx_eop   = 1'b1;
         if (!tx_seen) begin
            tx_seen        = 1'b1;
            tx_first_cycle = cycle_cnt;
         end
         tx_last_cycle = cycle_cnt;
         @(negedge i_clk_status);
         i_tx_valid = 1'b0;
         i_tx_ready = 1'b0;
         i_tx_sop   = 1'b0;
         i_tx_eop   = 1'b0;
         pkt++;
         if (pkt < count) begin
            gap = (gap_arg == 0) ? int'((lcg_next() >> 24) % (MAX_GAP + 1)) : gap_arg;
            repeat (gap) @(negedge i_clk_status);
         end
      end
   endtask

   task automatic send_rx(input int count, input logic bad);
      logic [31:0] err_word;
      repeat (count) begin
         i_rx_valid = 1'b1;
         i_rx_sop   = 1'b1;
         i_rx_eop   = 1'b1;
         err_word   = lcg_next() % 32'd63 + 32'd1;
         i_rx_error = bad ? err_word[ERR_W-1:0] : '0;
         @(negedge i_clk_status);
      end
      i_rx_valid = 1'b0;
      i_rx_sop   = 1'b0;
      i_rx_eop   = 1'b0;
      i_rx_error = '0;
   endtask

   // end minus start is the distance between first and last tx beat
   task automatic check_tx_span();
      status_word_t start_lo;
      status_word_t start_hi;
      status_word_t end_lo;
      status_word_t end_hi;
      read_word(block_addr(REG_TX_START_LO), start_lo);
      read_word(block_addr(REG_TX_START_HI), start_hi);
      read_word(block_addr(REG_TX_END_LO), end_lo);
      read_word(block_addr(REG_TX_END_HI), end_hi);
      check_value("tx end - tx start", {end_hi, end_lo} - {start_hi, start_lo},
                  64'(tx_last_cycle - tx_first_cycle));
   endtask

   ///////////////////////////////////////////////////////////////////////
   // stimulus file
   ///////////////////////////////////////////////////////////////////////

   task automatic load_stimulus();
      int          fd;
      int          n;
      int          c;
      int          cycles;
      string       cmd;
      logic [31:0] a;
      logic [31:0] b;
      fd = $fopen("verification/perf_stimulus.txt", "r");
      if (fd == 0) begin
         $display("cannot open verification/perf_stimulus.txt");
         stop_on_failure();
      end
      cycles = 2;
      while ($fscanf(fd, "%s", cmd) == 1) begin
         a = '0;
         b = '0;
         n = 0;
         if (cmd == "#") begin
            c = $fgetc(fd);
            while (c != 10 && c != -1) begin
               c = $fgetc(fd);
            end
         end else begin
            if (cmd == "WR" || cmd == "RD" || cmd == "TX") begin
               n = $fscanf(fd, "%h %h", a, b);
               if (n != 2) begin
                  $display("command %s is missing an operand", cmd);
                  stop_on_failure();
               end
            end else if (cmd == "RDX" || cmd == "RXG" || cmd == "RXE" || cmd == "IDLE") begin
               n = $fscanf(fd, "%h", a);
               if (n != 1) begin
                  $display("command %s is missing an operand", cmd);
                  stop_on_failure();
               end
            end else if (cmd != "TSPAN") begin
               $display("unknown command %s in the stimulus file", cmd);
               stop_on_failure();
            end
            if (cmd == "WR") cycles += 1;
            else if (cmd == "RD" || cmd == "RDX") cycles += 2;
            else if (cmd == "TX") cycles += a * (1 + ((b == 0) ? MAX_GAP : b));
            else if (cmd == "TSPAN") cycles += 8;
            else cycles += a;
            cmd_q.push_back(cmd);
            arg_a_q.push_back(a);
            arg_b_q.push_back(b);
         end
      end
      $fclose(fd);
      cycle_limit = cycles + MARGIN;
   endtask

   task automatic run_command(input string cmd, input logic [31:0] a, input logic [31:0] b);
      status_word_t data;
      logic         got_valid;
      if (cmd == "WR") begin
         bus_write(a[BUS_ADDR_W-1:0], b);
      end else if (cmd == "RD") begin
         read_word(a[BUS_ADDR_W-1:0], data);
         check_value($sformatf("o_status_readdata at 0x%04h", a[BUS_ADDR_W-1:0]),
                     {32'h0, data}, {32'h0, b});
      end else if (cmd == "RDX") begin
         bus_read(a[BUS_ADDR_W-1:0], data, got_valid);
         if (got_valid) begin
            $display("read at 0x%04h outside the block gave a valid pulse", a[15:0]);
            stop_on_failure();
         end
      end else if (cmd == "TX") begin
         send_tx(a, b);
      end else if (cmd == "RXG") begin
         send_rx(a, 1'b0);
      end else if (cmd == "RXE") begin
         send_rx(a, 1'b1);
      end else if (cmd == "IDLE") begin
         repeat (a) @(negedge i_clk_status);
      end else begin
         check_tx_span();
      end
   endtask

   initial begin
      perf_count_rst     = 1'b1;
      i_tx_valid         = 1'b0;
      i_tx_ready         = 1'b0;
      i_tx_sop           = 1'b0;
      i_tx_eop           = 1'b0;
      i_rx_valid         = 1'b0;
      i_rx_sop           = 1'b0;
      i_rx_eop           = 1'b0;
      i_rx_error         = '0;
      i_status_addr      = '0;
      i_status_read      = 1'b0;
      i_status_write     = 1'b0;
      i_status_writedata = '0;
      lcg_state          = 32'h1e3b_b49a;
      cycle_limit        = 0;
      error_cnt          = 0;
      tx_seen            = 1'b0;
      tx_first_cycle     = 0;
      tx_last_cycle      = 0;
      load_stimulus();

      repeat (2) @(posedge i_clk_status);
      @(negedge i_clk_status);
      perf_count_rst = 1'b0;

      foreach (cmd_q[i]) begin
         run_command(cmd_q[i], arg_a_q[i], arg_b_q[i]);
      end

      if (error_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule
